// File: source/arena_pkg.sv
`default_nettype none

package arena_pkg;

    // arena geometry
    localparam int grid_dim   = 16;
    localparam int coord_w    = 4;
    localparam int cell_w     = 8;
    localparam int cell_count = 256;

    // last valid x or y, used for the far-edge checks
    localparam logic [coord_w-1:0] coord_max = coord_w'(grid_dim - 1);

    // direction codes as driven by the player inputs
    localparam int dir_w = 3;
    localparam logic [dir_w-1:0] dir_up    = 3'd0;
    localparam logic [dir_w-1:0] dir_down  = 3'd1;
    localparam logic [dir_w-1:0] dir_left  = 3'd2;
    localparam logic [dir_w-1:0] dir_right = 3'd3;
    localparam logic [dir_w-1:0] dir_stop  = 3'd4;

    // facing keeps the low bits of a move direction
    localparam int facing_w = 2;

    // bomb bookkeeping
    localparam int bomb_cnt_w        = 3;
    localparam int bomb_rearm_cycles = 2;
    localparam int rearm_cnt_w       = $clog2(bomb_rearm_cycles + 1);

    // corner start cells
    localparam logic [cell_w-1:0] p1_start_cell = 8'd0;
    localparam logic [cell_w-1:0] p2_start_cell = 8'd255;

    // one cell word, seen either as a linear index or as row/column.
    // y sits in the upper nibble so index is always 16*y + x
    typedef union packed {
        logic [cell_w-1:0] index;
        struct packed {
            logic [coord_w-1:0] y;
            logic [coord_w-1:0] x;
        } xy;
    } cell_addr_u;

endpackage

`default_nettype wire

// File: source/grid_probe.sv
`timescale 1ns/1ps
`default_nettype none

module grid_probe (
    input  arena_pkg::cell_addr_u              cell_i,
    input  logic [arena_pkg::dir_w-1:0]        dir_i,
    input  logic [arena_pkg::cell_count-1:0]   solid_map_i,
    input  logic [arena_pkg::cell_count-1:0]   bomb_map_i,
    output arena_pkg::cell_addr_u              target_o,
    output logic                               enter_ok_o
);

    arena_pkg::cell_addr_u target;
    logic                  off_grid;
    logic                  is_move;
    logic                  solid_hit;
    logic                  bomb_hit;

    // one step in xy space, flag if it would leave the arena
    always_comb begin
        target   = cell_i;
        off_grid = 1'b0;
        is_move  = 1'b1;
        case (dir_i)
            arena_pkg::dir_up: begin
                if (cell_i.xy.y == '0) begin
                    off_grid = 1'b1;
                end else begin
                    target.xy.y = cell_i.xy.y - 1'b1;
                end
            end
            arena_pkg::dir_down: begin
                if (cell_i.xy.y == arena_pkg::coord_max) begin
                    off_grid = 1'b1;
                end else begin
                    target.xy.y = cell_i.xy.y + 1'b1;
                end
            end
            arena_pkg::dir_left: begin
                if (cell_i.xy.x == '0) begin
                    off_grid = 1'b1;
                end else begin
                    target.xy.x = cell_i.xy.x - 1'b1;
                end
            end
            arena_pkg::dir_right: begin
                if (cell_i.xy.x == arena_pkg::coord_max) begin
                    off_grid = 1'b1;
                end else begin
                    target.xy.x = cell_i.xy.x + 1'b1;
                end
            end
            default: begin
                // stop or unused code
                is_move = 1'b0;
            end
        endcase
    end

    // map lookups by linear index
    assign solid_hit = solid_map_i[target.index];
    assign bomb_hit  = bomb_map_i[target.index];

    assign target_o   = target;
    assign enter_ok_o = is_move && !off_grid && !solid_hit && !bomb_hit;

endmodule

`default_nettype wire

// File: source/bomb_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module bomb_dispatcher (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_i,
    input  logic                                bomb_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    bomb_count_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    bomb_limit_i,
    output logic                                set_bomb_o
);

    logic                                 armed_q;
    logic [arena_pkg::rearm_cnt_w-1:0]    rearm_q;
    logic                                 set_bomb_q;
    logic                                 place;

    // placement needs a live request, an armed unit and room under the limit
    assign place = valid_i && bomb_i && armed_q && (bomb_count_i < bomb_limit_i);

    // one-cycle pulse on accept
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            set_bomb_q <= 1'b0;
        end else begin
            set_bomb_q <= place;
        end
    end

    // cooldown after each placement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed_q <= 1'b1;
            rearm_q <= '0;
        end else if (place) begin
            armed_q <= 1'b0;
            rearm_q <= arena_pkg::rearm_cnt_w'(arena_pkg::bomb_rearm_cycles);
        end else if (!armed_q) begin
            // last count of the window, armed again on the next edge
            if (rearm_q == arena_pkg::rearm_cnt_w'(1)) begin
                armed_q <= 1'b1;
            end
            rearm_q <= rearm_q - 1'b1;
        end
    end

    assign set_bomb_o = set_bomb_q;

endmodule

`default_nettype wire

// File: source/player_unit.sv
`timescale 1ns/1ps
`default_nettype none

module player_unit #(
    parameter logic [arena_pkg::cell_w-1:0] start_cell = arena_pkg::p1_start_cell
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [arena_pkg::dir_w-1:0]         dir_i,
    input  logic                                valid_i,
    input  logic                                bomb_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    bomb_count_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    bomb_limit_i,
    input  logic [arena_pkg::cell_count-1:0]    solid_map_i,
    input  logic [arena_pkg::cell_count-1:0]    bomb_map_i,
    output arena_pkg::cell_addr_u               cell_o,
    output logic [arena_pkg::facing_w-1:0]      facing_o,
    output logic                                set_bomb_o
);

    arena_pkg::cell_addr_u                  cell_q;
    arena_pkg::cell_addr_u                  target;
    logic [arena_pkg::facing_w-1:0]         facing_q;
    logic                                   lockout_q;
    logic                                   enter_ok;
    logic                                   dir_is_move;
    logic                                   move_req;
    logic                                   move_ok;

    // target cell and blocking check for the current request
    grid_probe u_probe (
        .cell_i      (cell_q),
        .dir_i       (dir_i),
        .solid_map_i (solid_map_i),
        .bomb_map_i  (bomb_map_i),
        .target_o    (target),
        .enter_ok_o  (enter_ok)
    );

    bomb_dispatcher u_bomb (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .bomb_i       (bomb_i),
        .bomb_count_i (bomb_count_i),
        .bomb_limit_i (bomb_limit_i),
        .set_bomb_o   (set_bomb_o)
    );

    assign dir_is_move = (dir_i != arena_pkg::dir_stop);
    assign move_req    = valid_i && dir_is_move;

    // step only when not locked out and the target is free
    assign move_ok = move_req && !lockout_q && enter_ok;

    // position register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cell_q.index <= start_cell;
        end else if (move_ok) begin
            cell_q <= target;
        end
    end

    // lockout is armed by any request seen while clear, even a blocked one.
    // it always drops after one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lockout_q <= 1'b0;
        end else if (lockout_q) begin
            lockout_q <= 1'b0;
        end else begin
            lockout_q <= move_req;
        end
    end

    // facing tracks the key even without valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            facing_q <= arena_pkg::dir_up[arena_pkg::facing_w-1:0];
        end else if (dir_is_move) begin
            facing_q <= dir_i[arena_pkg::facing_w-1:0];
        end
    end

    assign cell_o   = cell_q;
    assign facing_o = facing_q;

endmodule

`default_nettype wire

// File: source/arena_controller.sv
`timescale 1ns/1ps
`default_nettype none

module arena_controller (
    input  logic                                clk,
    input  logic                                rst,

    // player 1 requests
    input  logic [arena_pkg::dir_w-1:0]         p1_dir_i,
    input  logic                                p1_valid_i,
    input  logic                                p1_bomb_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    p1_bomb_count_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    p1_bomb_limit_i,

    // player 2 requests
    input  logic [arena_pkg::dir_w-1:0]         p2_dir_i,
    input  logic                                p2_valid_i,
    input  logic                                p2_bomb_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    p2_bomb_count_i,
    input  logic [arena_pkg::bomb_cnt_w-1:0]    p2_bomb_limit_i,

    // shared arena maps, 1 marks a blocked cell
    input  logic [arena_pkg::cell_count-1:0]    solid_map_i,
    input  logic [arena_pkg::cell_count-1:0]    bomb_map_i,

    // player 1 state
    output arena_pkg::cell_addr_u               p1_cell_o,
    output logic [arena_pkg::facing_w-1:0]      p1_facing_o,
    output logic                                p1_set_bomb_o,

    // player 2 state
    output arena_pkg::cell_addr_u               p2_cell_o,
    output logic [arena_pkg::facing_w-1:0]      p2_facing_o,
    output logic                                p2_set_bomb_o
);

    // top-left corner
    player_unit #(
        .start_cell (arena_pkg::p1_start_cell)
    ) u_player1 (
        .clk          (clk),
        .rst          (rst),
        .dir_i        (p1_dir_i),
        .valid_i      (p1_valid_i),
        .bomb_i       (p1_bomb_i),
        .bomb_count_i (p1_bomb_count_i),
        .bomb_limit_i (p1_bomb_limit_i),
        .solid_map_i  (solid_map_i),
        .bomb_map_i   (bomb_map_i),
        .cell_o       (p1_cell_o),
        .facing_o     (p1_facing_o),
        .set_bomb_o   (p1_set_bomb_o)
    );

    // bottom-right corner
    player_unit #(
        .start_cell (arena_pkg::p2_start_cell)
    ) u_player2 (
        .clk          (clk),
        .rst          (rst),
        .dir_i        (p2_dir_i),
        .valid_i      (p2_valid_i),
        .bomb_i       (p2_bomb_i),
        .bomb_count_i (p2_bomb_count_i),
        .bomb_limit_i (p2_bomb_limit_i),
        .solid_map_i  (solid_map_i),
        .bomb_map_i   (bomb_map_i),
        .cell_o       (p2_cell_o),
        .facing_o     (p2_facing_o),
        .set_bomb_o   (p2_set_bomb_o)
    );

endmodule

`default_nettype wire

// File: bench/arena_checks.svh
`ifndef arena_checks_svh
`define arena_checks_svh

// compare tasks, one per result type

task automatic check_cell(input string name, input arena_pkg::cell_addr_u got,
                          input arena_pkg::cell_addr_u exp);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got.index, exp.index);
    end
endtask

task automatic check_facing(input string name, input logic [arena_pkg::facing_w-1:0] got,
                            input logic [arena_pkg::facing_w-1:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

// linear cell number, 16 per row
function automatic arena_pkg::cell_addr_u cell_of(input int x, input int y);
    arena_pkg::cell_addr_u c;
    c.index = 8'(16 * y + x);
    return c;
endfunction

function automatic int next_x(input int x, input logic [arena_pkg::dir_w-1:0] dir);
    if (dir == arena_pkg::dir_left) begin
        return x - 1;
    end
    if (dir == arena_pkg::dir_right) begin
        return x + 1;
    end
    return x;
endfunction

function automatic int next_y(input int y, input logic [arena_pkg::dir_w-1:0] dir);
    if (dir == arena_pkg::dir_up) begin
        return y - 1;
    end
    if (dir == arena_pkg::dir_down) begin
        return y + 1;
    end
    return y;
endfunction

// true when one step lands on the grid, on a cell free in both maps
function automatic bit step_free(input int x, input int y,
                                 input logic [arena_pkg::dir_w-1:0] dir);
    int nx;
    int ny;
    nx = next_x(x, dir);
    ny = next_y(y, dir);
    if (dir > arena_pkg::dir_right) begin
        return 1'b0;
    end
    if (nx < 0 || nx > 15 || ny < 0 || ny > 15) begin
        return 1'b0;
    end
    return !solid_map[16 * ny + nx] && !bomb_map[16 * ny + nx];
endfunction

// cells that some walk can reach, kept clear of random walls
function automatic bit in_walk(input int idx);
    int x;
    int y;
    x = idx % 16;
    y = idx / 16;
    return (x < 8 && y < 4) || (x >= 12 && y >= 12);
endfunction

`endif

// File: bench/arena_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arena_tb;

    localparam int reset_cycles  = 5;
    // reset, open walk, blocking, lockout, bombs, both players
    localparam int test_cycles   = reset_cycles + 10 + 11 + 7 + 18 + 13;
    localparam int timeout_limit = test_cycles + 40;

    logic                                clk;
    logic                                rst;
    logic [arena_pkg::dir_w-1:0]         p1_dir;
    logic                                p1_valid;
    logic                                p1_bomb;
    logic [arena_pkg::bomb_cnt_w-1:0]    p1_bomb_count;
    logic [arena_pkg::bomb_cnt_w-1:0]    p1_bomb_limit;
    logic [arena_pkg::dir_w-1:0]         p2_dir;
    logic                                p2_valid;
    logic                                p2_bomb;
    logic [arena_pkg::bomb_cnt_w-1:0]    p2_bomb_count;
    logic [arena_pkg::bomb_cnt_w-1:0]    p2_bomb_limit;
    logic [arena_pkg::cell_count-1:0]    solid_map;
    logic [arena_pkg::cell_count-1:0]    bomb_map;
    arena_pkg::cell_addr_u               p1_cell;
    arena_pkg::cell_addr_u               p2_cell;
    logic [arena_pkg::facing_w-1:0]      p1_facing;
    logic [arena_pkg::facing_w-1:0]      p2_facing;
    logic                                p1_set_bomb;
    logic                                p2_set_bomb;

    int     error_count;
    int     cycle_count;
    integer seed;

    // reference model state with player 1 at index 0
    int                              mx [2];
    int                              my [2];
    logic                            mlock [2];
    logic [arena_pkg::facing_w-1:0]  mface [2];
    int                              mhold [2];
    logic                            mpulse [2];

    `include "arena_checks.svh"

    arena_controller dut (
        .clk             (clk),
        .rst             (rst),
        .p1_dir_i        (p1_dir),
        .p1_valid_i      (p1_valid),
        .p1_bomb_i       (p1_bomb),
        .p1_bomb_count_i (p1_bomb_count),
        .p1_bomb_limit_i (p1_bomb_limit),
        .p2_dir_i        (p2_dir),
        .p2_valid_i      (p2_valid),
        .p2_bomb_i       (p2_bomb),
        .p2_bomb_count_i (p2_bomb_count),
        .p2_bomb_limit_i (p2_bomb_limit),
        .solid_map_i     (solid_map),
        .bomb_map_i      (bomb_map),
        .p1_cell_o       (p1_cell),
        .p1_facing_o     (p1_facing),
        .p1_set_bomb_o   (p1_set_bomb),
        .p2_cell_o       (p2_cell),
        .p2_facing_o     (p2_facing),
        .p2_set_bomb_o   (p2_set_bomb)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // one player across a rising edge
    task automatic model_edge(input int p, input logic [arena_pkg::dir_w-1:0] dir,
                              input logic valid, input logic bomb,
                              input logic [arena_pkg::bomb_cnt_w-1:0] count,
                              input logic [arena_pkg::bomb_cnt_w-1:0] limit);
        logic move_req;
        logic place;
        move_req = valid && (dir != arena_pkg::dir_stop);
        if (move_req && !mlock[p] && step_free(mx[p], my[p], dir)) begin
            mx[p] = next_x(mx[p], dir);
            my[p] = next_y(my[p], dir);
        end
        mlock[p] = mlock[p] ? 1'b0 : move_req;
        if (dir != arena_pkg::dir_stop) begin
            mface[p] = dir[arena_pkg::facing_w-1:0];
        end
        place = valid && bomb && (mhold[p] == 0) && (count < limit);
        mpulse[p] = place;
        if (place) begin
            mhold[p] = arena_pkg::bomb_rearm_cycles;
        end else if (mhold[p] > 0) begin
            mhold[p] = mhold[p] - 1;
        end
    endtask

    // one clock, then compare both players with the model
    task automatic run_cycle();
        model_edge(0, p1_dir, p1_valid, p1_bomb, p1_bomb_count, p1_bomb_limit);
        model_edge(1, p2_dir, p2_valid, p2_bomb, p2_bomb_count, p2_bomb_limit);
        @(negedge clk);
        check_cell("p1_cell_o", p1_cell, cell_of(mx[0], my[0]));
        check_facing("p1_facing_o", p1_facing, mface[0]);
        check_bit("p1_set_bomb_o", p1_set_bomb, mpulse[0]);
        check_cell("p2_cell_o", p2_cell, cell_of(mx[1], my[1]));
        check_facing("p2_facing_o", p2_facing, mface[1]);
        check_bit("p2_set_bomb_o", p2_set_bomb, mpulse[1]);
    endtask

    task automatic set_idle();
        p1_dir   = arena_pkg::dir_stop;
        p1_valid = 1'b0;
        p1_bomb  = 1'b0;
        p2_dir   = arena_pkg::dir_stop;
        p2_valid = 1'b0;
        p2_bomb  = 1'b0;
    endtask

    // one request cycle for both players, then an idle cycle
    task automatic request_pair(input logic [arena_pkg::dir_w-1:0] d1, input logic v1,
                                input logic b1, input logic [arena_pkg::dir_w-1:0] d2,
                                input logic v2, input logic b2);
        p1_dir   = d1;
        p1_valid = v1;
        p1_bomb  = b1;
        p2_dir   = d2;
        p2_valid = v2;
        p2_bomb  = b2;
        run_cycle();
        set_idle();
        run_cycle();
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        set_idle();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        mx[0] = 0;
        my[0] = 0;
        mx[1] = 15;
        my[1] = 15;
        for (int p = 0; p < 2; p++) begin
            mlock[p]  = 1'b0;
            mface[p]  = arena_pkg::dir_up[arena_pkg::facing_w-1:0];
            mhold[p]  = 0;
            mpulse[p] = 1'b0;
        end
    endtask

    task automatic place_walls();
        for (int i = 0; i < arena_pkg::cell_count; i++) begin
            if (!in_walk(i) && (($random(seed) & 3) == 0)) begin
                solid_map[i] = 1'b1;
            end
        end
    endtask

    task automatic test_reset();
        apply_reset();
        check_cell("p1_cell_o", p1_cell, cell_of(0, 0));
        check_cell("p2_cell_o", p2_cell, cell_of(15, 15));
        check_facing("p1_facing_o", p1_facing, 2'd0);
        check_facing("p2_facing_o", p2_facing, 2'd0);
        check_bit("p1_set_bomb_o", p1_set_bomb, 1'b0);
        check_bit("p2_set_bomb_o", p2_set_bomb, 1'b0);
    endtask

    task automatic test_open();
        repeat (3) request_pair(arena_pkg::dir_right, 1'b1, 1'b0, arena_pkg::dir_stop, 1'b0, 1'b0);
        repeat (2) request_pair(arena_pkg::dir_down, 1'b1, 1'b0, arena_pkg::dir_stop, 1'b0, 1'b0);
        check_cell("p1_cell_o", p1_cell, cell_of(3, 2));
    endtask

    task automatic test_blocking();
        // wall east of (3,2), bomb south of it
        solid_map[16 * 2 + 4] = 1'b1;
        bomb_map[16 * 3 + 3]  = 1'b1;
        request_pair(arena_pkg::dir_right, 1'b1, 1'b0, arena_pkg::dir_stop, 1'b0, 1'b0);
        check_cell("p1_cell_o", p1_cell, cell_of(3, 2));
        check_facing("p1_facing_o", p1_facing, 2'd3);
        request_pair(arena_pkg::dir_down, 1'b1, 1'b0, arena_pkg::dir_stop, 1'b0, 1'b0);
        check_cell("p1_cell_o", p1_cell, cell_of(3, 2));
        check_facing("p1_facing_o", p1_facing, 2'd1);
        solid_map[16 * 2 + 4] = 1'b0;
        bomb_map[16 * 3 + 3]  = 1'b0;
        repeat (2) request_pair(arena_pkg::dir_up, 1'b1, 1'b0, arena_pkg::dir_stop, 1'b0, 1'b0);
        // turn down without valid, then push against the top edge
        p1_dir = arena_pkg::dir_down;
        run_cycle();
        check_facing("p1_facing_o", p1_facing, 2'd1);
        request_pair(arena_pkg::dir_up, 1'b1, 1'b0, arena_pkg::dir_stop, 1'b0, 1'b0);
        check_cell("p1_cell_o", p1_cell, cell_of(3, 0));
        check_facing("p1_facing_o", p1_facing, 2'd0);
    endtask

    task automatic test_lockout();
        p1_dir   = arena_pkg::dir_right;
        p1_valid = 1'b1;
        repeat (6) run_cycle();
        set_idle();
        run_cycle();
        check_cell("p1_cell_o", p1_cell, cell_of(6, 0));
    endtask

    task automatic test_bomb();
        p1_bomb_count = 3'd1;
        p1_bomb_limit = 3'd2;
        p1_valid      = 1'b1;
        p1_bomb       = 1'b1;
        for (int j = 0; j < 7; j++) begin
            run_cycle();
            check_bit("p1_set_bomb_o", p1_set_bomb, (j % 3) == 0);
        end
        set_idle();
        repeat (3) run_cycle();
        // at the limit nothing may be placed
        p1_bomb_count = 3'd2;
        p1_valid      = 1'b1;
        p1_bomb       = 1'b1;
        repeat (7) begin
            run_cycle();
            check_bit("p1_set_bomb_o", p1_set_bomb, 1'b0);
        end
        set_idle();
        run_cycle();
    endtask

    task automatic test_independence();
        apply_reset();
        p1_bomb_count = 3'd0;
        p1_bomb_limit = 3'd1;
        p2_bomb_count = 3'd2;
        p2_bomb_limit = 3'd3;
        request_pair(arena_pkg::dir_down, 1'b1, 1'b1, arena_pkg::dir_up, 1'b1, 1'b0);
        request_pair(arena_pkg::dir_right, 1'b1, 1'b1, arena_pkg::dir_left, 1'b1, 1'b1);
        request_pair(arena_pkg::dir_down, 1'b1, 1'b0, arena_pkg::dir_up, 1'b1, 1'b1);
        request_pair(arena_pkg::dir_right, 1'b1, 1'b1, arena_pkg::dir_left, 1'b1, 1'b0);
        check_cell("p1_cell_o", p1_cell, cell_of(2, 2));
        check_cell("p2_cell_o", p2_cell, cell_of(13, 13));
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        error_count   = 0;
        cycle_count   = 0;
        seed          = 32'h5589cf5e;
        p1_bomb_count = '0;
        p1_bomb_limit = '0;
        p2_bomb_count = '0;
        p2_bomb_limit = '0;
        solid_map     = '0;
        bomb_map      = '0;
        set_idle();
        place_walls();
        test_reset();
        test_open();
        test_blocking();
        test_lockout();
        test_bomb();
        test_independence();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+bench
source/arena_pkg.sv
source/grid_probe.sv
source/bomb_dispatcher.sv
source/player_unit.sv
source/arena_controller.sv
bench/arena_tb.sv
